//--- src/exu_pkg.sv
// Word types and control codes for the RV64 execute stage; codes outside these lists are unused.
`default_nettype none

package exu_pkg;

  // Data and address width.
  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] xlen_t;

  // ALU control code.
  typedef logic [3:0] alu_ctr_t;

  localparam alu_ctr_t ALU_ADD     = 4'b0000;
  localparam alu_ctr_t ALU_COPY    = 4'b0011;
  localparam alu_ctr_t ALU_SUB     = 4'b1000;
  localparam alu_ctr_t ALU_ADDW    = 4'b1001;
  localparam alu_ctr_t ALU_SLT     = 4'b1010;
  // These two only raise flags in the retire register.
  localparam alu_ctr_t ALU_EBREAK  = 4'b1110;
  localparam alu_ctr_t ALU_ILLEGAL = 4'b1111;

  // Second ALU operand select.
  typedef logic [1:0] b_src_t;

  localparam b_src_t BSRC_RS2  = 2'b00;
  localparam b_src_t BSRC_IMM  = 2'b01;
  localparam b_src_t BSRC_FOUR = 2'b10;

  // Branch code.
  typedef logic [2:0] branch_t;

  localparam branch_t BR_NONE = 3'b000;
  localparam branch_t BR_JAL  = 3'b001;
  localparam branch_t BR_JALR = 3'b010;
  localparam branch_t BR_BEQ  = 3'b100;
  localparam branch_t BR_BNE  = 3'b101;
  localparam branch_t BR_BLT  = 3'b110;
  localparam branch_t BR_BGE  = 3'b111;

  // Sequential PC step.
  localparam xlen_t PC_STEP = xlen_t'(4);

endpackage

`default_nettype wire

//--- src/exu_op_if.sv
// Operand and control bundle of one instruction; the branch code travels as br_code.
`timescale 1ns/1ps
`default_nettype none

interface exu_op_if import exu_pkg::*; ();

  xlen_t    rs1;
  xlen_t    rs2;
  xlen_t    imm;
  xlen_t    pc;
  logic     a_src;
  b_src_t   b_src;
  alu_ctr_t alu_ctr;
  branch_t  br_code;

  // Filled from the top-level input ports.
  modport driver (
    output rs1, rs2, imm, pc, a_src, b_src, alu_ctr, br_code
  );

  modport alu (
    input rs1, rs2, imm, pc, a_src, b_src, alu_ctr
  );

  modport branch (
    input rs1, rs2, imm, pc, br_code
  );

  // Flag decode only.
  modport retire (
    input alu_ctr
  );

endinterface

`default_nettype wire

//--- src/exu_alu.sv
// Combinational ALU with add, sub, slt, addw and copy-immediate only; other codes give zero.
`timescale 1ns/1ps
`default_nettype none

module exu_alu import exu_pkg::*; (
  exu_op_if.alu op,
  output xlen_t o_result
);

  xlen_t op_a;
  xlen_t op_b;
  xlen_t sum;
  xlen_t diff;
  xlen_t sum_w;

  assign op_a = op.a_src ? op.pc : op.rs1;

  always_comb begin
    case (op.b_src)
      BSRC_RS2: begin
        op_b = op.rs2;
      end
      BSRC_IMM: begin
        op_b = op.imm;
      end
      BSRC_FOUR: begin
        op_b = PC_STEP;
      end
      default: begin
        op_b = '0;
      end
    endcase
  end

  assign sum  = op_a + op_b;
  assign diff = op_a - op_b;

  // Word result, sign-extended from bit 31.
  assign sum_w = {{(XLEN-32){sum[31]}}, sum[31:0]};

  always_comb begin
    case (op.alu_ctr)
      ALU_ADD: begin
        o_result = sum;
      end
      ALU_SUB: begin
        o_result = diff;
      end
      ALU_ADDW: begin
        o_result = sum_w;
      end
      ALU_SLT: begin
        o_result = {{(XLEN-1){1'b0}}, diff[XLEN-1]};
      end
      ALU_COPY: begin
        o_result = op.imm;
      end
      default: begin
        o_result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/exu_branch.sv
// Branch condition and next PC; less uses the sign of rs1 - rs2, so it is wrong on overflow.
`timescale 1ns/1ps
`default_nettype none

module exu_branch import exu_pkg::*; (
  exu_op_if.branch op,
  output xlen_t    o_next_pc
);

  xlen_t diff;
  logic  equal;
  logic  less;
  logic  taken;
  xlen_t base;
  xlen_t offset;

  // Own comparator, independent of the ALU.
  assign diff  = op.rs1 - op.rs2;
  assign equal = (diff == '0);
  assign less  = diff[XLEN-1];

  always_comb begin
    case (op.br_code)
      BR_JAL, BR_JALR: begin
        taken = 1'b1;
      end
      BR_BEQ: begin
        taken = equal;
      end
      BR_BNE: begin
        taken = ~equal;
      end
      BR_BLT: begin
        taken = less;
      end
      BR_BGE: begin
        taken = ~less;
      end
      default: begin
        taken = 1'b0;
      end
    endcase
  end

  assign base   = (op.br_code == BR_JALR) ? op.rs1 : op.pc;
  assign offset = taken ? op.imm : PC_STEP;

  assign o_next_pc = base + offset;

endmodule

`default_nettype wire

//--- src/exu_retire.sv
// Single-entry output register with valid/ready on both sides; holds at most one item.
`timescale 1ns/1ps
`default_nettype none

module exu_retire import exu_pkg::*; (
  input  logic        i_clk,
  input  logic        i_arst_n,
  exu_op_if.retire    op,
  input  xlen_t       i_alu_result,
  input  xlen_t       i_next_pc,
  input  logic        i_valid,
  output logic        o_ready,
  output logic        o_valid,
  input  logic        i_ready,
  output xlen_t       o_result,
  output xlen_t       o_next_pc,
  output logic        o_halt,
  output logic        o_illegal
);

  logic  valid_q;
  logic  halt_q;
  logic  illegal_q;
  xlen_t result_q;
  xlen_t next_pc_q;
  logic  load;
  logic  drain;

  // Accept when empty or when the held item leaves this cycle.
  assign o_ready = ~valid_q | i_ready;
  assign load    = i_valid & o_ready;
  assign drain   = valid_q & i_ready;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      valid_q   <= 1'b0;
      halt_q    <= 1'b0;
      illegal_q <= 1'b0;
    end else if (load) begin
      valid_q   <= 1'b1;
      halt_q    <= (op.alu_ctr == ALU_EBREAK);
      illegal_q <= (op.alu_ctr == ALU_ILLEGAL);
    end else if (drain) begin
      valid_q   <= 1'b0;
      halt_q    <= 1'b0;
      illegal_q <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (load) begin
      result_q  <= i_alu_result;
      next_pc_q <= i_next_pc;
    end
  end

  assign o_valid   = valid_q;
  assign o_halt    = halt_q;
  assign o_illegal = illegal_q;
  assign o_result  = result_q;
  assign o_next_pc = next_pc_q;

endmodule

`default_nettype wire

//--- src/exu_top.sv
// Execute stage top with one cycle from input transfer to o_valid; no fetch, decode or memory.
`timescale 1ns/1ps
`default_nettype none

module exu_top import exu_pkg::*; (
  input  logic     i_clk,
  input  logic     i_arst_n,

  // Instruction input side.
  input  logic     i_valid,
  output logic     o_ready,
  input  xlen_t    i_rs1,
  input  xlen_t    i_rs2,
  input  xlen_t    i_imm,
  input  xlen_t    i_pc,
  input  logic     i_a_src,
  input  b_src_t   i_b_src,
  input  alu_ctr_t i_alu_ctr,
  input  branch_t  i_branch,

  // Result output side.
  output logic     o_valid,
  input  logic     i_ready,
  output xlen_t    o_result,
  output xlen_t    o_next_pc,
  output logic     o_halt,
  output logic     o_illegal
);

  xlen_t alu_result;
  xlen_t next_pc;

  exu_op_if op ();

  assign op.rs1     = i_rs1;
  assign op.rs2     = i_rs2;
  assign op.imm     = i_imm;
  assign op.pc      = i_pc;
  assign op.a_src   = i_a_src;
  assign op.b_src   = i_b_src;
  assign op.alu_ctr = i_alu_ctr;
  assign op.br_code = i_branch;

  exu_alu u_alu (
    .op       (op),
    .o_result (alu_result)
  );

  exu_branch u_branch (
    .op        (op),
    .o_next_pc (next_pc)
  );

  exu_retire u_retire (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .op           (op),
    .i_alu_result (alu_result),
    .i_next_pc    (next_pc),
    .i_valid      (i_valid),
    .o_ready      (o_ready),
    .o_valid      (o_valid),
    .i_ready      (i_ready),
    .o_result     (o_result),
    .o_next_pc    (o_next_pc),
    .o_halt       (o_halt),
    .o_illegal    (o_illegal)
  );

endmodule

`default_nettype wire

//--- test/exu_chk.sv
// Handshake and reset checks for exu_retire; the reset check samples on the clock edge only.
`timescale 1ns/1ps
`default_nettype none

module exu_chk import exu_pkg::*; (
  input logic  i_clk,
  input logic  i_arst_n,
  input logic  o_valid,
  input logic  i_ready,
  input logic  o_ready,
  input logic  o_halt,
  input logic  o_illegal,
  input xlen_t o_result,
  input xlen_t o_next_pc
);

  int unsigned fire_count = 0;

  // Nothing is presented while reset is held.
  a_reset_idle: assert property (@(posedge i_clk)
    !i_arst_n |-> (!o_valid && !o_halt && !o_illegal))
    else begin
      fire_count++;
      $error("outputs active during reset");
    end

  // A stalled item keeps its valid and its data.
  a_hold_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (o_valid && !i_ready) |=> (o_valid && $stable(o_result) && $stable(o_next_pc)
                               && $stable(o_halt) && $stable(o_illegal)))
    else begin
      fire_count++;
      $error("outputs changed while stalled");
    end

  a_ready_rule: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_ready == (!o_valid || i_ready))
    else begin
      fire_count++;
      $error("o_ready differs from empty or draining");
    end

endmodule

`default_nettype wire

//--- test/tb_exu.sv
// Execute stage testbench; the model checks results in order, so it assumes one item in flight.
`timescale 1ns/1ps
`default_nettype none

module tb_exu import exu_pkg::*; ();

  localparam int CLK_HALF    = 4;
  localparam int RST_CYCLES  = 8;
  localparam int N_ALU       = 200;
  localparam int N_BR        = 72;
  localparam int N_FLAG      = 8;
  localparam int N_BP        = 300;
  localparam int N_TP        = 64;
  localparam int N_ITEMS     = N_ALU + N_BR + N_FLAG + N_BP + N_TP;
  localparam int TIMEOUT_CYC = N_ITEMS * 4 + 200;
  localparam int DRAIN_CYC   = 16;

  typedef struct packed {
    xlen_t result;
    xlen_t next_pc;
    logic  halt;
    logic  illegal;
  } exp_t;

  logic     i_clk;
  logic     i_arst_n;
  logic     i_valid;
  logic     o_ready;
  xlen_t    i_rs1;
  xlen_t    i_rs2;
  xlen_t    i_imm;
  xlen_t    i_pc;
  logic     i_a_src;
  b_src_t   i_b_src;
  alu_ctr_t i_alu_ctr;
  branch_t  i_branch;
  logic     o_valid;
  logic     i_ready;
  xlen_t    o_result;
  xlen_t    o_next_pc;
  logic     o_halt;
  logic     o_illegal;

  int   seed = 34;
  int   errors = 0;
  int   test_err0 = 0;
  int   tests_pass = 0;
  int   tests_fail = 0;
  int   n_in = 0;
  int   n_out = 0;
  logic bp_on;
  logic exp_valid;
  exp_t exp_q[$];

  alu_ctr_t alu_tab[5]  = '{ALU_ADD, ALU_SUB, ALU_ADDW, ALU_SLT, ALU_COPY};
  b_src_t   bsrc_tab[3] = '{BSRC_RS2, BSRC_IMM, BSRC_FOUR};
  branch_t  br_tab[8]   = '{BR_NONE, BR_JAL, BR_JALR, 3'b011, BR_BEQ, BR_BNE, BR_BLT, BR_BGE};

  exu_top UUT (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_valid   (i_valid),
    .o_ready   (o_ready),
    .i_rs1     (i_rs1),
    .i_rs2     (i_rs2),
    .i_imm     (i_imm),
    .i_pc      (i_pc),
    .i_a_src   (i_a_src),
    .i_b_src   (i_b_src),
    .i_alu_ctr (i_alu_ctr),
    .i_branch  (i_branch),
    .o_valid   (o_valid),
    .i_ready   (i_ready),
    .o_result  (o_result),
    .o_next_pc (o_next_pc),
    .o_halt    (o_halt),
    .o_illegal (o_illegal)
  );

  bind exu_retire exu_chk u_chk (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .o_valid   (o_valid),
    .i_ready   (i_ready),
    .o_ready   (o_ready),
    .o_halt    (o_halt),
    .o_illegal (o_illegal),
    .o_result  (o_result),
    .o_next_pc (o_next_pc)
  );

  initial begin
    i_clk = 1'b0;
    forever #CLK_HALF i_clk = ~i_clk;
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge i_clk);
    $display("ERROR: watchdog expired after %0d cycles, items stopped moving", TIMEOUT_CYC);
    $display("TEST FAIL");
    $finish;
  end

  function automatic xlen_t rand_word();
    rand_word = {$random(seed), $random(seed)};
  endfunction

  // Expected ALU result from the operand and code rules.
  function automatic xlen_t model_result(input xlen_t rs1, input xlen_t rs2, input xlen_t imm,
                                         input xlen_t pc, input logic a_src,
                                         input b_src_t b_src, input alu_ctr_t ctr);
    xlen_t a;
    xlen_t b;
    xlen_t s;
    xlen_t d;
    int    w;
    a = a_src ? pc : rs1;
    if (b_src == BSRC_RS2) b = rs2;
    else if (b_src == BSRC_IMM) b = imm;
    else if (b_src == BSRC_FOUR) b = 64'd4;
    else b = '0;
    s = a + b;
    d = a - b;
    w = s[31:0];
    if (ctr == ALU_ADD) model_result = s;
    else if (ctr == ALU_SUB) model_result = d;
    else if (ctr == ALU_ADDW) model_result = w;
    else if (ctr == ALU_SLT) model_result = d[XLEN-1] ? 64'd1 : 64'd0;
    else if (ctr == ALU_COPY) model_result = imm;
    else model_result = '0;
  endfunction

  function automatic xlen_t model_next_pc(input xlen_t rs1, input xlen_t rs2, input xlen_t imm,
                                          input xlen_t pc, input branch_t br);
    xlen_t d;
    logic  take;
    d = rs1 - rs2;
    take = (br == BR_JAL) || (br == BR_JALR) || (br == BR_BEQ && d == '0)
        || (br == BR_BNE && d != '0) || (br == BR_BLT && d[XLEN-1])
        || (br == BR_BGE && !d[XLEN-1]);
    model_next_pc = ((br == BR_JALR) ? rs1 : pc) + (take ? imm : 64'd4);
  endfunction

  // The scoreboard pops before it pushes since a pop always belongs to an older item.
  always @(posedge i_clk) begin : monitor
    exp_t e;
    exp_t m;
    if (!i_arst_n) begin
      exp_valid = 1'b0;
    end else begin
      assert (o_valid == exp_valid) else begin
        $display("FAIL o_valid exp %h got %h", exp_valid, o_valid);
        errors++;
      end
      if (o_valid && i_ready) begin
        if (exp_q.size() == 0) begin
          $display("ERROR: output transfer with no item outstanding");
          errors++;
        end else begin
          e = exp_q.pop_front();
          n_out++;
          assert (o_result == e.result) else begin
            $display("FAIL o_result exp %h got %h", e.result, o_result);
            errors++;
          end
          assert (o_next_pc == e.next_pc) else begin
            $display("FAIL o_next_pc exp %h got %h", e.next_pc, o_next_pc);
            errors++;
          end
          assert (o_halt == e.halt) else begin
            $display("FAIL o_halt exp %h got %h", e.halt, o_halt);
            errors++;
          end
          assert (o_illegal == e.illegal) else begin
            $display("FAIL o_illegal exp %h got %h", e.illegal, o_illegal);
            errors++;
          end
        end
      end
      if (i_valid && o_ready) begin
        m.result  = model_result(i_rs1, i_rs2, i_imm, i_pc, i_a_src, i_b_src, i_alu_ctr);
        m.next_pc = model_next_pc(i_rs1, i_rs2, i_imm, i_pc, i_branch);
        m.halt    = (i_alu_ctr == ALU_EBREAK);
        m.illegal = (i_alu_ctr == ALU_ILLEGAL);
        exp_q.push_back(m);
      end
      exp_valid = (i_valid && o_ready) || (o_valid && !i_ready);
    end
  end

  // Sink readiness is random only while back-pressure is on.
  always @(posedge i_clk) begin : sink
    logic [31:0] r;
    #1;
    r = $random(seed);
    i_ready = bp_on ? r[0] : 1'b1;
  end

  task automatic send_item(input xlen_t rs1, input xlen_t rs2, input xlen_t imm, input xlen_t pc,
                           input logic a_src, input b_src_t b_src, input alu_ctr_t ctr,
                           input branch_t br, output int stalls);
    stalls    = 0;
    i_rs1     = rs1;
    i_rs2     = rs2;
    i_imm     = imm;
    i_pc      = pc;
    i_a_src   = a_src;
    i_b_src   = b_src;
    i_alu_ctr = ctr;
    i_branch  = br;
    i_valid   = 1'b1;
    @(posedge i_clk);
    while (!o_ready) begin
      stalls++;
      @(posedge i_clk);
    end
    n_in++;
    #1;
    i_valid = 1'b0;
  endtask

  task automatic send_random(input alu_ctr_t ctr, input b_src_t b_src, input branch_t br,
                             output int stalls);
    logic [31:0] r;
    r = $random(seed);
    send_item(rand_word(), rand_word(), rand_word(), rand_word(), r[0], b_src, ctr, br, stalls);
  endtask

  task automatic check_idle_outputs();
    assert (!o_valid) else begin
      $display("FAIL o_valid exp 0 got %h", o_valid);
      errors++;
    end
    assert (!o_halt) else begin
      $display("FAIL o_halt exp 0 got %h", o_halt);
      errors++;
    end
    assert (!o_illegal) else begin
      $display("FAIL o_illegal exp 0 got %h", o_illegal);
      errors++;
    end
  endtask

  // Waits on the falling edge, where the queue has settled.
  task automatic drain();
    int waited;
    waited = 0;
    while (n_out != n_in && waited < DRAIN_CYC) begin
      @(negedge i_clk);
      waited++;
    end
    assert (n_in == n_out && exp_q.size() == 0) else begin
      $display("ERROR: %0d items went in but %0d came out", n_in, n_out);
      errors++;
    end
    @(posedge i_clk);
    #1;
  endtask

  task automatic end_test(input string name);
    drain();
    if (errors == test_err0) begin
      tests_pass++;
      $display("test %s: ok", name);
    end else begin
      tests_fail++;
      $display("test %s: %0d errors", name, errors - test_err0);
    end
    test_err0 = errors;
  endtask

  initial begin : main
    int          stalls;
    logic [31:0] r;
    xlen_t       rs2;
    xlen_t       delta;
    i_arst_n  = 1'b0;
    i_valid   = 1'b1;
    i_ready   = 1'b1;
    i_rs1     = '0;
    i_rs2     = '0;
    i_imm     = '0;
    i_pc      = '0;
    i_a_src   = 1'b0;
    i_b_src   = BSRC_RS2;
    i_alu_ctr = ALU_EBREAK;
    i_branch  = BR_NONE;
    bp_on     = 1'b0;
    exp_valid = 1'b0;

    // An item is offered all through reset and must not be captured.
    for (int k = 0; k < RST_CYCLES; k++) begin
      @(posedge i_clk);
      check_idle_outputs();
      #1;
      i_alu_ctr = (k < RST_CYCLES / 2 - 1) ? ALU_EBREAK : ALU_ILLEGAL;
    end
    i_valid  = 1'b0;
    i_arst_n = 1'b1;
    @(posedge i_clk);
    check_idle_outputs();
    #1;
    end_test("reset");

    for (int i = 0; i < N_ALU; i++) begin
      send_random(alu_tab[i % 5], bsrc_tab[(i / 5) % 3], br_tab[i % 8], stalls);
    end
    end_test("alu");

    for (int c = 0; c < 8; c++) begin
      for (int k = 0; k < 6; k++) begin
        send_random(alu_tab[k % 5], bsrc_tab[k % 3], br_tab[c], stalls);
      end
      r     = $random(seed);
      rs2   = rand_word();
      delta = {48'b0, r[15:0]} + 64'd1;
      send_item(rs2, rs2, rand_word(), rand_word(), 1'b0, BSRC_RS2, ALU_SUB, br_tab[c], stalls);
      send_item(rs2 + delta, rs2, rand_word(), rand_word(), 1'b0, BSRC_RS2, ALU_SLT, br_tab[c],
                stalls);
      send_item(rs2 - delta, rs2, rand_word(), rand_word(), 1'b0, BSRC_RS2, ALU_SLT, br_tab[c],
                stalls);
    end
    end_test("branch");

    send_random(ALU_ADD, BSRC_RS2, BR_NONE, stalls);
    send_random(ALU_EBREAK, BSRC_IMM, BR_NONE, stalls);
    send_random(ALU_ADD, BSRC_IMM, BR_JAL, stalls);
    send_random(ALU_ILLEGAL, BSRC_RS2, BR_BEQ, stalls);
    send_random(ALU_EBREAK, BSRC_FOUR, BR_BNE, stalls);
    send_random(ALU_ILLEGAL, BSRC_FOUR, BR_NONE, stalls);
    send_random(ALU_SUB, BSRC_RS2, BR_BLT, stalls);
    send_random(ALU_ADD, BSRC_RS2, BR_NONE, stalls);
    end_test("flags");

    bp_on = 1'b1;
    for (int i = 0; i < N_BP; i++) begin
      r = $random(seed);
      if (r[4:0] == 5'd0) begin
        send_random(ALU_EBREAK, bsrc_tab[i % 3], br_tab[i % 8], stalls);
      end else if (r[4:0] == 5'd1) begin
        send_random(ALU_ILLEGAL, bsrc_tab[i % 3], br_tab[i % 8], stalls);
      end else begin
        send_random(alu_tab[i % 5], bsrc_tab[i % 3], br_tab[i % 8], stalls);
      end
    end
    bp_on = 1'b0;
    end_test("backpressure");

    for (int i = 0; i < N_TP; i++) begin
      send_random(alu_tab[i % 5], bsrc_tab[i % 3], br_tab[i % 8], stalls);
      assert (stalls == 0) else begin
        $display("ERROR: item %0d waited %0d cycles with i_ready high", i, stalls);
        errors++;
      end
    end
    end_test("throughput");

    $display("tests passed %0d, failed %0d, bound checks fired %0d",
             tests_pass, tests_fail, UUT.u_retire.u_chk.fire_count);
    if (tests_fail == 0 && UUT.u_retire.u_chk.fire_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
src/exu_pkg.sv
src/exu_op_if.sv
src/exu_alu.sv
src/exu_branch.sv
src/exu_retire.sv
src/exu_top.sv
test/exu_chk.sv
test/tb_exu.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_exu
FILELIST = build.f

.PHONY: sim clean

# The run passes only when the pass line shows up in the output.
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q -x "TEST PASS"

clean:
	rm -rf obj_dir
